//--- run_sim.sh
#!/bin/sh
# Build the Vigna core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    -f vigna_core.f --top-module tb_vigna_core \
    -Mdir obj_dir -o tb_vigna_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_vigna_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0

//--- tb_vigna_core.sv
// Testbench for the Vigna core
// Runs short directed programs against instruction and data memory models
// and compares every store with an RV32I reference model

`timescale 1ns/1ps
`include "vigna_defines.svh"

module tb_vigna_core;

    localparam int          MAX_CYCLES = 6 * 40 * 40; // Tests x instructions x worst case
    localparam logic [31:0] NOP        = 32'h0000_0013; // addi x0, x0, 0

    logic        clk          = 1'b0;
    logic        resetn       = 1'b0;
    logic        i_imem_ready = 1'b0;
    logic [31:0] i_imem_rdata = '0;
    logic        i_dmem_ready = 1'b0;
    logic [31:0] i_dmem_rdata = '0;
    logic        o_imem_valid;
    logic [31:0] o_imem_addr;
    logic        o_dmem_valid;
    logic [31:0] o_dmem_addr;
    logic [31:0] o_dmem_wdata;
    logic [3:0]  o_dmem_wstrb;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] mmem [0:255]; // Model view of data memory
    logic [31:0] mreg [0:31];  // Model register file
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] cap_addr [$]; // Stores seen on the data port
    logic [31:0] cap_data [$];
    logic [31:0] exp_fetch;
    integer      seed = 32'h91e1_e8d1;
    int          iwait;
    int          dwait;
    logic        imem_rand = 1'b1;
    int          prog_len;
    int          slot;
    int          cycles = 0;
    int          check_errors = 0;
    int          bus_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    vigna_core u_dut (
        .clk          (clk),
        .resetn       (resetn),
        .o_imem_valid (o_imem_valid),
        .o_imem_addr  (o_imem_addr),
        .i_imem_ready (i_imem_ready),
        .i_imem_rdata (i_imem_rdata),
        .o_dmem_valid (o_dmem_valid),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_wstrb (o_dmem_wstrb),
        .i_dmem_ready (i_dmem_ready),
        .i_dmem_rdata (i_dmem_rdata)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////
    // Reference model

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        sext12 = {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        fill_word = (idx * 32'h9e37_79b9) ^ 32'hc3c3_5a5a;
    endfunction

    // RV32I integer results by funct3, alt selects sub and sra
    function automatic logic [31:0] expected_alu(input logic [2:0] f3, input logic alt,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    expected_alu = alt ? a - b : a + b;
            3'd1:    expected_alu = a << b[4:0];
            3'd2:    expected_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    expected_alu = (a < b) ? 32'd1 : 32'd0;
            3'd4:    expected_alu = a ^ b;
            3'd5: begin
                if (alt) expected_alu = $signed(a) >>> b[4:0];
                else     expected_alu = a >> b[4:0];
            end
            3'd6:    expected_alu = a | b;
            default: expected_alu = a & b;
        endcase
    endfunction

    function automatic void report_mismatch(input string sig, input logic [31:0] exp,
                                            input logic [31:0] got);
        $display("mismatch at %0t: %s expected %08h got %08h", $time, sig, exp, got);
    endfunction

    ////////////////////
    // Memory models, driven on the falling edge
    always @(negedge clk) begin
        if (!resetn) begin
            i_imem_ready <= 1'b0;
            i_dmem_ready <= 1'b0;
            iwait = 0;
            dwait = 0;
            exp_fetch = `VIGNA_RESET_ADDR;
            cap_addr.delete();
            cap_data.delete();
            for (int i = 0; i < 256; i++) begin
                dmem[i] = fill_word(i);
            end
        end else begin
            if (i_imem_ready) begin
                i_imem_ready <= 1'b0; // Taken on the last rising edge
            end else if (o_imem_valid) begin
                if (iwait == 0) begin
                    if (o_imem_addr !== exp_fetch) begin
                        report_mismatch("o_imem_addr", exp_fetch, o_imem_addr);
                        bus_errors++;
                    end
                    exp_fetch = exp_fetch + 32'd4;
                    i_imem_ready <= 1'b1;
                    i_imem_rdata <= imem[o_imem_addr[9:2]];
                    iwait = imem_rand ? ($random(seed) & 3) : 0;
                end else begin
                    iwait = iwait - 1;
                end
            end

            if (i_dmem_ready) begin
                i_dmem_ready <= 1'b0;
            end else if (o_dmem_valid) begin
                if (dwait == 0) begin
                    i_dmem_ready <= 1'b1;
                    i_dmem_rdata <= dmem[o_dmem_addr[9:2]];
                    if (o_dmem_wstrb !== 4'b0000) begin
                        if (o_dmem_wstrb !== 4'b1111) begin
                            report_mismatch("o_dmem_wstrb", 32'hf, {28'd0, o_dmem_wstrb});
                            bus_errors++;
                        end
                        dmem[o_dmem_addr[9:2]] = o_dmem_wdata;
                        cap_addr.push_back(o_dmem_addr);
                        cap_data.push_back(o_dmem_wdata);
                    end
                    dwait = $random(seed) & 3;
                end else begin
                    dwait = dwait - 1;
                end
            end
        end
    end

    ////////////////////
    // Program builder, each call also updates the model

    task automatic new_program;
        @(posedge clk); // Keeps random draws off the falling edge
        prog_len = 0;
        slot = 0;
        imem_rand = 1'b1;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 256; i++) begin
            imem[i] = NOP;
            mmem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            mreg[i] = '0;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len[7:0]] = word;
        prog_len++;
    endtask

    task automatic reg_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        emit({1'b0, alt, 5'b00000, rs2, rs1, f3, rd, 7'b0110011});
        if (rd != 5'd0) mreg[rd] = expected_alu(f3, alt, mreg[rs1], mreg[rs2]);
    endtask

    task automatic imm_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        logic alt;
        alt = (f3 == 3'd5) && imm[10]; // srai
        emit({imm, rs1, f3, rd, 7'b0010011});
        if (rd != 5'd0) mreg[rd] = expected_alu(f3, alt, mreg[rs1], sext12(imm));
    endtask

    task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
        emit({imm, rd, 7'b0110111});
        if (rd != 5'd0) mreg[rd] = {imm, 12'h000};
    endtask

    // lui plus addi, upper part rounded for the signed low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [19:0] hi;
        hi = value[31:12] + {19'd0, value[11]};
        load_upper(rd, hi);
        imm_op(3'b000, rd, rd, value[11:0]);
    endtask

    task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                              input logic [11:0] imm);
        logic [31:0] addr;
        addr = mreg[rs1] + sext12(imm);
        emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011});
        exp_addr.push_back(addr);
        exp_data.push_back(mreg[rs2]);
        mmem[addr[9:2]] = mreg[rs2];
    endtask

    task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [11:0] imm);
        logic [31:0] addr;
        addr = mreg[rs1] + sext12(imm);
        emit({imm, rs1, 3'b010, rd, 7'b0000011});
        if (rd != 5'd0) mreg[rd] = mmem[addr[9:2]];
    endtask

    // Result slots from 0x100 upward
    task automatic store_result(input logic [4:0] rs);
        logic [11:0] off;
        off = 12'h100 + 12'(slot * 4);
        store_word(rs, 5'd0, off);
        slot++;
    endtask

    ////////////////////
    // Run control

    task automatic reset_dut;
        @(negedge clk);
        resetn <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            @(negedge clk);
            if (o_imem_valid !== 1'b0) begin
                report_mismatch("o_imem_valid", 32'd0, {31'd0, o_imem_valid});
                check_errors++;
            end
            if (o_dmem_valid !== 1'b0) begin
                report_mismatch("o_dmem_valid", 32'd0, {31'd0, o_dmem_valid});
                check_errors++;
            end
            if (o_dmem_wstrb !== 4'b0000) begin
                report_mismatch("o_dmem_wstrb", 32'd0, {28'd0, o_dmem_wstrb});
                check_errors++;
            end
        end
        resetn <= 1'b1;
        @(negedge clk);
    endtask

    // Ends on the store count, the global counter catches a hang
    task automatic run_program;
        reset_dut();
        while (cap_addr.size() < exp_addr.size()) @(negedge clk);
        for (int i = 0; i < exp_addr.size(); i++) begin
            if (cap_addr[i] !== exp_addr[i]) begin
                report_mismatch($sformatf("o_dmem_addr of store %0d", i), exp_addr[i],
                                cap_addr[i]);
                check_errors++;
            end
            if (cap_data[i] !== exp_data[i]) begin
                report_mismatch($sformatf("o_dmem_wdata of store %0d", i), exp_data[i],
                                cap_data[i]);
                check_errors++;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        int errs;
        errs = check_errors + bus_errors - errs_before;
        if (errs == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    ////////////////////
    // Directed tests

    task automatic reset_and_fetch;
        int errs;
        errs = check_errors + bus_errors;
        new_program();
        imm_op(3'b000, 5'd1, 5'd0, 12'h055);
        imm_op(3'b000, 5'd2, 5'd1, 12'h7ff);
        imm_op(3'b000, 5'd3, 5'd2, 12'h800); // Most negative immediate
        store_result(5'd1);
        store_result(5'd2);
        store_result(5'd3);
        run_program();
        finish_test("reset and fetch order", errs);
    endtask

    task automatic alu_ops;
        int errs;
        errs = check_errors + bus_errors;
        new_program();
        load_const(5'd1, 32'h7fff_ffff);
        load_const(5'd2, 32'h8000_0000);
        load_const(5'd3, 32'hffff_fff6);
        imm_op(3'b000, 5'd4, 5'd0, 12'h019);
        reg_op(3'b000, 1'b0, 5'd5, 5'd1, 5'd4);  // Signed overflow
        reg_op(3'b000, 1'b1, 5'd6, 5'd3, 5'd1);
        reg_op(3'b010, 1'b0, 5'd7, 5'd2, 5'd4);
        reg_op(3'b011, 1'b0, 5'd8, 5'd2, 5'd4);
        reg_op(3'b100, 1'b0, 5'd9, 5'd1, 5'd3);
        reg_op(3'b110, 1'b0, 5'd10, 5'd2, 5'd4);
        reg_op(3'b111, 1'b0, 5'd11, 5'd3, 5'd1);
        imm_op(3'b000, 5'd12, 5'd3, 12'h800);
        imm_op(3'b010, 5'd13, 5'd2, 12'hfff);
        imm_op(3'b011, 5'd14, 5'd4, 12'hfff);   // Unsigned max after extension
        imm_op(3'b100, 5'd15, 5'd1, 12'hfff);
        imm_op(3'b110, 5'd16, 5'd2, 12'h123);
        imm_op(3'b111, 5'd17, 5'd3, 12'h0f0);
        load_upper(5'd18, 20'habcde);
        for (int r = 5; r <= 18; r++) begin
            store_result(5'(r));
        end
        run_program();
        finish_test("alu operations", errs);
    endtask

    task automatic shift_ops;
        int         errs;
        logic [4:0] amts [4] = '{5'd0, 5'd1, 5'd17, 5'd31};
        errs = check_errors + bus_errors;
        new_program();
        load_const(5'd1, 32'h8765_4321); // Negative
        load_const(5'd2, 32'h5a3c_0f81); // Positive
        foreach (amts[k]) begin
            imm_op(3'b001, 5'd3, 5'd1, {7'b0000000, amts[k]});
            imm_op(3'b101, 5'd4, 5'd1, {7'b0000000, amts[k]});
            imm_op(3'b101, 5'd5, 5'd1, {7'b0100000, amts[k]});
            imm_op(3'b000, 5'd6, 5'd0, {7'b0000000, amts[k]});
            reg_op(3'b001, 1'b0, 5'd7, 5'd2, 5'd6);
            reg_op(3'b101, 1'b0, 5'd8, 5'd1, 5'd6);
            reg_op(3'b101, 1'b1, 5'd9, 5'd1, 5'd6);
            reg_op(3'b101, 1'b1, 5'd10, 5'd2, 5'd6);
            store_result(5'd3);
            store_result(5'd4);
            store_result(5'd5);
            store_result(5'd7);
            store_result(5'd8);
            store_result(5'd9);
            store_result(5'd10);
        end
        run_program();
        finish_test("shifts", errs);
    endtask

    task automatic load_store;
        int errs;
        errs = check_errors + bus_errors;
        new_program();
        imm_op(3'b000, 5'd5, 5'd0, 12'h200); // Base address
        load_const(5'd1, 32'hdead_beef);
        load_const(5'd2, 32'h0123_4567);
        store_word(5'd1, 5'd5, 12'h008);
        store_word(5'd2, 5'd5, 12'hffc);
        load_word(5'd3, 5'd5, 12'h008);
        load_word(5'd4, 5'd5, 12'hffc);
        store_word(5'd3, 5'd5, 12'h010);
        store_word(5'd4, 5'd5, 12'hff0);
        load_word(5'd6, 5'd5, 12'h040);      // Untouched fill word
        store_result(5'd6);
        store_word(5'd1, 5'd5, 12'h000);
        load_word(5'd7, 5'd5, 12'h000);      // Right after its store
        store_result(5'd7);
        reg_op(3'b000, 1'b0, 5'd8, 5'd3, 5'd4);
        store_result(5'd8);
        run_program();
        finish_test("load and store", errs);
    endtask

    task automatic stall_and_backpressure;
        int         errs;
        logic [4:0] rd;
        errs = check_errors + bus_errors;
        new_program();
        for (int i = 0; i < 10; i++) begin
            rd = 5'(i + 1);
            imm_op(3'b000, rd, 5'(i), 12'($random(seed)));
            if (i % 2 == 0) imm_op(3'b001, rd, rd, 12'd31);
            else            imm_op(3'b101, rd, rd, {7'b0100000, 5'd17});
            reg_op(3'b000, 1'b0, rd, rd, 5'(i));
        end
        for (int r = 1; r <= 10; r++) begin
            store_result(5'(r));
        end
        run_program();            // Random fetch latency
        @(posedge clk);
        imem_rand = 1'b0;         // Fetch runs ahead and fills the queue
        run_program();
        finish_test("fetch stalls and queue back-pressure", errs);
    endtask

    task automatic x0_and_nops;
        int errs;
        errs = check_errors + bus_errors;
        new_program();
        load_const(5'd1, 32'h1357_9bdf);
        imm_op(3'b000, 5'd2, 5'd0, 12'h0aa);
        imm_op(3'b000, 5'd0, 5'd0, 12'h123);
        load_upper(5'd0, 20'hfffff);
        reg_op(3'b000, 1'b0, 5'd0, 5'd1, 5'd2);
        load_word(5'd0, 5'd0, 12'h300);
        store_result(5'd0);
        emit(32'hffff_ffff); // Unknown major opcode with rd x31
        emit(32'h0040_00ef); // jal x1, 4
        emit(32'h0000_0063); // beq x0, x0, 0
        emit(32'h0000_1117); // auipc x2, 1
        imm_op(3'b000, 5'd3, 5'd1, 12'h001);
        store_result(5'd1);
        store_result(5'd2);
        store_result(5'd3);
        store_result(5'd31);
        store_result(5'd0);
        run_program();
        finish_test("x0 and unsupported opcodes", errs);
    endtask

    initial begin
        reset_and_fetch();
        alu_ops();
        shift_ops();
        load_store();
        stall_and_backpressure();
        x0_and_nops();
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && check_errors + bus_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- vigna_core.f
+incdir+.
vigna_isa_pkg.sv
vigna_ctrl_pkg.sv
vigna_inst_if.sv
vigna_fetch.sv
vigna_inst_fifo.sv
vigna_exec.sv
vigna_core.sv
tb_vigna_core.sv

//--- vigna_core.sv
// Vigna core top level
// Small in-order RV32I subset core with a prefetch queue
// between the fetch unit and the execute unit

`timescale 1ns/1ps
`include "vigna_defines.svh"

module vigna_core (
    input  logic                   clk,
    input  logic                   resetn,

    // Instruction port
    output logic                   o_imem_valid,
    output logic [`VIGNA_XLEN-1:0] o_imem_addr,
    input  logic                   i_imem_ready,
    input  logic [`VIGNA_XLEN-1:0] i_imem_rdata,

    // Data port
    output logic                   o_dmem_valid,
    output logic [`VIGNA_XLEN-1:0] o_dmem_addr,
    output logic [`VIGNA_XLEN-1:0] o_dmem_wdata,
    output logic [3:0]             o_dmem_wstrb,
    input  logic                   i_dmem_ready,
    input  logic [`VIGNA_XLEN-1:0] i_dmem_rdata
);

    vigna_inst_if fetch_q (); // Fetch to queue
    vigna_inst_if q_exec ();  // Queue to execute

    vigna_fetch u_fetch (
        .clk          (clk),
        .resetn       (resetn),
        .o_imem_valid (o_imem_valid),
        .o_imem_addr  (o_imem_addr),
        .i_imem_ready (i_imem_ready),
        .i_imem_rdata (i_imem_rdata),
        .o_inst       (fetch_q.producer)
    );

    vigna_inst_fifo #(
        .DEPTH (`VIGNA_FIFO_DEPTH)
    ) u_fifo (
        .clk    (clk),
        .resetn (resetn),
        .i_inst (fetch_q.consumer),
        .o_inst (q_exec.producer)
    );

    vigna_exec u_exec (
        .clk          (clk),
        .resetn       (resetn),
        .i_inst       (q_exec.consumer),
        .o_dmem_valid (o_dmem_valid),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_wstrb (o_dmem_wstrb),
        .i_dmem_ready (i_dmem_ready),
        .i_dmem_rdata (i_dmem_rdata)
    );

endmodule

//--- vigna_ctrl_pkg.sv
// Vigna control types
// States of the execute unit

package vigna_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,     // Waiting for an instruction
        st_calc,     // ALU write back
        st_shift,    // One bit per cycle
        st_mem_req,  // Drive the data port
        st_mem_wait  // Wait for data ready
    } exec_state_e;

endpackage

//--- vigna_defines.svh
// Vigna core build parameters
// Data width, register count, reset address and prefetch queue depth

`ifndef VIGNA_DEFINES_SVH
`define VIGNA_DEFINES_SVH

// Data and address width
`define VIGNA_XLEN 32

// Architectural registers, x0 included
`define VIGNA_NREGS 32

// First fetch address after reset
`define VIGNA_RESET_ADDR 32'h0000_0000

// Prefetch queue entries, power of two
`define VIGNA_FIFO_DEPTH 4

`endif

//--- vigna_exec.sv
// Vigna execute unit
// Decodes one instruction at a time, holds the register file, runs the ALU,
// the bit-serial shifter and the word load/store sequence

`timescale 1ns/1ps
`include "vigna_defines.svh"

module vigna_exec (
    input  logic                   clk,
    input  logic                   resetn,
    vigna_inst_if.consumer         i_inst,

    output logic                   o_dmem_valid,
    output logic [`VIGNA_XLEN-1:0] o_dmem_addr,
    output logic [`VIGNA_XLEN-1:0] o_dmem_wdata,
    output logic [3:0]             o_dmem_wstrb,
    input  logic                   i_dmem_ready,
    input  logic [`VIGNA_XLEN-1:0] i_dmem_rdata
);

    import vigna_isa_pkg::*;
    import vigna_ctrl_pkg::*;

    function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    logic [`VIGNA_XLEN-1:0] regs [1:`VIGNA_NREGS-1]; // x0 is not stored
    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    decoded_t               dec;
    logic [`VIGNA_XLEN-1:0] rs1_val;
    logic [`VIGNA_XLEN-1:0] rs2_val;
    logic [`VIGNA_XLEN-1:0] op_b;
    logic                   accept;

    exec_state_e            state;
    logic [`VIGNA_XLEN-1:0] d1, d2, d3; // Working operands
    alu_op_e                alu_op;
    logic [4:0]             wb_reg;    // Zero means no write back
    logic [4:0]             shift_cnt;
    logic                   mem_we;
    logic [`VIGNA_XLEN-1:0] alu_result;
    logic [`VIGNA_XLEN-1:0] shift_next;

    ////////////////////
    // Decode
    assign opcode = opcode_e'(i_inst.inst[6:0]);
    assign funct3 = i_inst.inst[14:12];
    assign funct7 = i_inst.inst[31:25];

    always_comb begin
        dec        = '0;
        dec.rd     = i_inst.inst[11:7];
        dec.rs1    = i_inst.inst[19:15];
        dec.rs2    = i_inst.inst[24:20];
        dec.alu_op = alu_add;
        case (opcode)
            opc_op: begin
                dec.reg_write = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                dec.alu_op    = alu_fn(funct3, funct7[5]);
                dec.is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
            end
            opc_op_imm: begin
                dec.reg_write = 1'b1;
                dec.imm       = {{(`VIGNA_XLEN-12){i_inst.inst[31]}}, i_inst.inst[31:20]};
                dec.alu_op    = alu_fn(funct3, (funct3 == 3'b101) && funct7[5]);
                dec.is_shift  = (funct3 == 3'b001) || (funct3 == 3'b101);
            end
            opc_load: begin
                dec.reg_write = 1'b1;
                dec.is_load   = 1'b1;
                dec.imm       = {{(`VIGNA_XLEN-12){i_inst.inst[31]}}, i_inst.inst[31:20]};
            end
            opc_store: begin
                dec.is_store = 1'b1;
                dec.imm      = {{(`VIGNA_XLEN-12){i_inst.inst[31]}},
                                i_inst.inst[31:25], i_inst.inst[11:7]};
            end
            opc_lui: begin
                dec.reg_write = 1'b1;
                dec.imm       = {i_inst.inst[31:12], 12'b0};
                dec.alu_op    = alu_pass_b;
            end
            default: ; // Unsupported, retires without effect
        endcase
    end

    // Register read, x0 reads zero
    assign rs1_val = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    // Second operand: register, shift amount or immediate
    assign op_b = (opcode == opc_op) ? rs2_val :
                  dec.is_shift       ? {{(`VIGNA_XLEN-5){1'b0}}, i_inst.inst[24:20]} :
                                       dec.imm;

    assign i_inst.ready = (state == st_idle); // Only idle takes a new word
    assign accept       = i_inst.valid & i_inst.ready;

    ////////////////////
    // ALU and shifter
    always_comb begin
        case (alu_op)
            alu_sub:    alu_result = d1 - d2;
            alu_slt:    alu_result = {{(`VIGNA_XLEN-1){1'b0}}, $signed(d1) < $signed(d2)};
            alu_sltu:   alu_result = {{(`VIGNA_XLEN-1){1'b0}}, d1 < d2};
            alu_xor:    alu_result = d1 ^ d2;
            alu_or:     alu_result = d1 | d2;
            alu_and:    alu_result = d1 & d2;
            alu_pass_b: alu_result = d2;
            default:    alu_result = d1 + d2; // Also load/store address
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_sll: shift_next = {d3[`VIGNA_XLEN-2:0], 1'b0};
            alu_sra: shift_next = {d3[`VIGNA_XLEN-1], d3[`VIGNA_XLEN-1:1]};
            default: shift_next = {1'b0, d3[`VIGNA_XLEN-1:1]};
        endcase
    end

    ////////////////////
    // Execute state machine
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= st_idle;
            wb_reg       <= '0;
            shift_cnt    <= '0;
            mem_we       <= 1'b0;
            o_dmem_valid <= 1'b0;
            o_dmem_wstrb <= 4'b0000;
            for (int i = 1; i < `VIGNA_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        d1     <= rs1_val;
                        d2     <= op_b;
                        d3     <= dec.is_shift ? rs1_val : rs2_val; // Store data otherwise
                        alu_op <= dec.alu_op;
                        wb_reg <= dec.reg_write ? dec.rd : 5'd0;
                        mem_we <= dec.is_store;
                        if (dec.is_load || dec.is_store) begin
                            state <= st_mem_req;
                        end else if (dec.is_shift) begin
                            shift_cnt <= op_b[4:0];
                            state     <= st_shift;
                        end else begin
                            state <= st_calc;
                        end
                    end
                end
                st_calc: begin
                    if (wb_reg != '0) regs[wb_reg] <= alu_result;
                    state <= st_idle;
                end
                st_shift: begin
                    if (shift_cnt == '0) begin
                        if (wb_reg != '0) regs[wb_reg] <= d3;
                        state <= st_idle;
                    end else begin
                        d3        <= shift_next;
                        shift_cnt <= shift_cnt - 5'd1;
                    end
                end
                st_mem_req: begin
                    o_dmem_valid <= 1'b1;
                    o_dmem_addr  <= alu_result; // Base plus immediate
                    o_dmem_wdata <= d3;
                    o_dmem_wstrb <= mem_we ? 4'b1111 : 4'b0000;
                    state        <= st_mem_wait;
                end
                st_mem_wait: begin
                    if (i_dmem_ready) begin
                        o_dmem_valid <= 1'b0;
                        o_dmem_wstrb <= 4'b0000;
                        if (!mem_we && wb_reg != '0) regs[wb_reg] <= i_dmem_rdata;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- vigna_fetch.sv
// Vigna fetch unit
// Keeps the program counter, requests words from the instruction port
// and offers each returned word to the prefetch queue

`timescale 1ns/1ps
`include "vigna_defines.svh"

module vigna_fetch (
    input  logic                   clk,
    input  logic                   resetn,

    output logic                   o_imem_valid,
    output logic [`VIGNA_XLEN-1:0] o_imem_addr,
    input  logic                   i_imem_ready,
    input  logic [`VIGNA_XLEN-1:0] i_imem_rdata,

    vigna_inst_if.producer         o_inst
);

    typedef enum logic [1:0] {
        fs_issue, // First request after reset
        fs_wait,  // Request out, waiting on memory
        fs_offer  // Word held for the queue
    } fetch_state_e;

    fetch_state_e           state;
    logic [`VIGNA_XLEN-1:0] pc;
    logic [`VIGNA_XLEN-1:0] inst_q; // Returned word

    assign o_imem_addr  = pc;
    assign o_inst.valid = (state == fs_offer);
    assign o_inst.inst  = inst_q;
    assign o_inst.pc    = pc;   // Still the address of the held word

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= fs_issue;
            pc           <= `VIGNA_RESET_ADDR;
            o_imem_valid <= 1'b0;
        end else begin
            case (state)
                fs_issue: begin
                    o_imem_valid <= 1'b1;
                    state        <= fs_wait;
                end
                fs_wait: begin
                    if (i_imem_ready) begin
                        inst_q       <= i_imem_rdata;
                        o_imem_valid <= 1'b0;
                        state        <= fs_offer;
                    end
                end
                fs_offer: begin
                    // Queue full keeps us here with the word
                    if (o_inst.ready) begin
                        pc           <= pc + `VIGNA_XLEN'd4;
                        o_imem_valid <= 1'b1;
                        state        <= fs_wait;
                    end
                end
                default: begin
                    o_imem_valid <= 1'b0;
                    state        <= fs_issue;
                end
            endcase
        end
    end

endmodule

//--- vigna_inst_fifo.sv
// Vigna prefetch queue
// Circular buffer of instruction and address pairs between fetch and execute

`timescale 1ns/1ps
`include "vigna_defines.svh"

module vigna_inst_fifo #(
    parameter int DEPTH = `VIGNA_FIFO_DEPTH
) (
    input  logic           clk,
    input  logic           resetn,
    vigna_inst_if.consumer i_inst,
    vigna_inst_if.producer o_inst
);

    localparam int               PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int               CNT_W    = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

    logic [`VIGNA_XLEN-1:0] inst_mem [DEPTH];
    logic [`VIGNA_XLEN-1:0] pc_mem   [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   push;
    logic                   pop;

    assign i_inst.ready = (count != CNT_W'(DEPTH)); // Drops when full and stalls fetch
    assign o_inst.valid = (count != '0);
    assign o_inst.inst  = inst_mem[rd_ptr];
    assign o_inst.pc    = pc_mem[rd_ptr];

    assign push = i_inst.valid & i_inst.ready;
    assign pop  = o_inst.valid & o_inst.ready;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            inst_mem[wr_ptr] <= i_inst.inst;
            pc_mem[wr_ptr]   <= i_inst.pc;
        end
    end

    ////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1; // Wraps at DEPTH
            if (pop)  rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

endmodule

//--- vigna_inst_if.sv
// Instruction handoff channel
// Carries a fetched word and its address with a valid/ready handshake

`timescale 1ns/1ps
`include "vigna_defines.svh"

interface vigna_inst_if;

    logic                   valid;
    logic                   ready;
    logic [`VIGNA_XLEN-1:0] inst;
    logic [`VIGNA_XLEN-1:0] pc;

    modport producer (output valid, output inst, output pc, input ready);
    modport consumer (input valid, input inst, input pc, output ready);

endinterface

//--- vigna_isa_pkg.sv
// Vigna instruction-set types
// Major opcodes of the kept RV32I subset, ALU operations and decoded fields

`include "vigna_defines.svh"

package vigna_isa_pkg;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011, // Register-register ALU
        opc_op_imm = 7'b0010011, // Register-immediate ALU
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_lui    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b // lui takes the immediate as is
    } alu_op_e;

    typedef struct packed {
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [`VIGNA_XLEN-1:0] imm;
        alu_op_e                alu_op;
        logic                   reg_write;
        logic                   is_load;
        logic                   is_store;
        logic                   is_shift;
    } decoded_t;

endpackage
